// File: rtl/pad_pkg.sv
`default_nettype none

package pad_pkg;

	// ==================================================
	// Counts fixed by the console
	// ==================================================

	localparam int N_USB   = 5;  // USB joysticks, also player slots
	localparam int N_LLAPI = 2;  // Serial pad ports

	// ==================================================
	// LLAPI controller family codes
	// ==================================================

	localparam logic [7:0] TYPE_GENESIS_A = 8'd20;
	localparam logic [7:0] TYPE_GENESIS_B = 8'd21;
	localparam logic [7:0] TYPE_TG16_A    = 8'd54;
	localparam logic [7:0] TYPE_TG16_B    = 8'd23;
	localparam logic [7:0] TYPE_SATURN_A  = 8'd8;
	localparam logic [7:0] TYPE_SATURN_B  = 8'd3;

	// Bit positions inside the LLAPI button word
	localparam int BIT_DPAD_LO  = 24;  // Right, up to 27 for up
	localparam int OSD_BIT_DOWN = 26;
	localparam int OSD_BIT_RUN  = 5;
	localparam int OSD_BIT_B    = 0;

	// ==================================================
	// Pad and port words
	// ==================================================

	// Active-high pad layout, same order as the USB joystick word
	typedef struct packed {
		logic       b6;
		logic       b5;
		logic       b4;
		logic       b3;
		logic       run;
		logic       select;
		logic       b2;
		logic       b1;
		logic [3:0] dpad;  // Up, down, left, right
	} pad_word_t;

	// Decoded output of one LLAPI serial core
	typedef struct packed {
		logic [31:0] buttons;
		logic [7:0]  ctype;    // Zero for no pad or an Atari-style pad
		logic        link_en;
	} llapi_port_t;

endpackage

`default_nettype wire

// File: rtl/pad_remap.sv
`timescale 1ns/1ps
`default_nettype none

module pad_remap (
	input  pad_pkg::llapi_port_t port,
	output pad_pkg::pad_word_t   pad
);

	logic [31:0] btn;

	assign btn = port.buttons;

	// ==================================================
	// Button layout by controller family
	// ==================================================

	always_comb begin
		pad.dpad = btn[pad_pkg::BIT_DPAD_LO +: 4];  // Same for every family

		case (port.ctype)
			pad_pkg::TYPE_GENESIS_A,
			pad_pkg::TYPE_GENESIS_B: begin
				pad.b6     = btn[6];
				pad.b5     = btn[3];
				pad.b4     = btn[2];
				pad.b3     = btn[0];
				pad.run    = btn[5];
				pad.select = btn[4];
				pad.b2     = btn[1];
				pad.b1     = btn[7];
			end

			// TurboGrafx pads, I and II on the two main face buttons
			pad_pkg::TYPE_TG16_A,
			pad_pkg::TYPE_TG16_B: begin
				pad.b6     = btn[3];
				pad.b5     = btn[2];
				pad.b4     = btn[8];
				pad.b3     = btn[9];
				pad.run    = btn[5];
				pad.select = btn[4];
				pad.b2     = btn[0];
				pad.b1     = btn[1];
			end

			// Genesis layout with select on the right trigger
			pad_pkg::TYPE_SATURN_A,
			pad_pkg::TYPE_SATURN_B: begin
				pad.b6     = btn[6];
				pad.b5     = btn[3];
				pad.b4     = btn[2];
				pad.b3     = btn[0];
				pad.run    = btn[5];
				pad.select = btn[9];
				pad.b2     = btn[1];
				pad.b1     = btn[7];
			end

			default: begin
				pad.b6     = btn[7];
				pad.b5     = btn[3];
				pad.b4     = btn[6];
				pad.b3     = btn[2];
				pad.run    = btn[5];
				pad.select = btn[4];
				pad.b2     = btn[0];
				pad.b1     = btn[1];
			end
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/pad_presence.sv
`timescale 1ns/1ps
`default_nettype none

module pad_presence (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic                 llapi_select,
	input  pad_pkg::llapi_port_t port,
	output logic                 in_use,
	output logic                 osd_combo
);

	logic pressed;  // Some button seen since reset
	logic any_btn;
	logic typed;

	assign any_btn = |port.buttons;
	assign typed   = |port.ctype;

	// ==================================================
	// Sticky button-seen flag
	// ==================================================

	// Type zero may be a real pad or nothing at all.
	// Trust it only once a button has been pressed
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pressed <= 1'b0;
		end else if (any_btn) begin
			pressed <= 1'b1;
		end
	end

	assign in_use = port.link_en & llapi_select & (typed | pressed);

	// Down + run + B opens the menu, port in use or not
	assign osd_combo = port.buttons[pad_pkg::OSD_BIT_DOWN]
		& port.buttons[pad_pkg::OSD_BIT_RUN]
		& port.buttons[pad_pkg::OSD_BIT_B];

	// ==================================================
	// Checks
	// ==================================================

	// Only reset may clear the flag
	a_pressed_sticky: assert property (
		@(posedge clk_sys) $past(pressed) && !$past(reset) |-> pressed
	);

endmodule

`default_nettype wire

// File: rtl/player_slot_mux.sv
`timescale 1ns/1ps
`default_nettype none

module player_slot_mux (
	input  logic               clk_sys,
	input  logic               reset,
	input  logic               use_a,
	input  logic               use_b,
	input  pad_pkg::pad_word_t ll_pad_a,
	input  pad_pkg::pad_word_t ll_pad_b,
	input  pad_pkg::pad_word_t usb_joy [pad_pkg::N_USB],
	input  logic               osd_a,
	input  logic               osd_b,
	output logic [11:0]        pce_joy [pad_pkg::N_USB],
	output logic               osd_button
);

	pad_pkg::pad_word_t slot [pad_pkg::N_USB];

	// Active-low joypad word, d-pad reordered for the console port
	function automatic logic [11:0] to_console(pad_pkg::pad_word_t w);
		return ~{w.b6, w.b5, w.b4, w.b3, w.run, w.select, w.b2, w.b1,
			w.dpad[1], w.dpad[2], w.dpad[0], w.dpad[3]};
	endfunction

	// ==================================================
	// Slot assignment
	// ==================================================

	// LLAPI pads take the first slots, USB pads move down behind them
	always_comb begin
		for (int i = 0; i < pad_pkg::N_USB; i++) begin
			slot[i] = usb_joy[i];
		end

		if (use_a && use_b) begin
			slot[0] = ll_pad_a;
			slot[1] = ll_pad_b;
			for (int i = pad_pkg::N_LLAPI; i < pad_pkg::N_USB; i++) begin
				slot[i] = usb_joy[i - pad_pkg::N_LLAPI];
			end
		end else if (use_a || use_b) begin
			slot[0] = use_a ? ll_pad_a : usb_joy[0];  // Port B keeps slot 1
			slot[1] = use_b ? ll_pad_b : usb_joy[0];
			for (int i = pad_pkg::N_LLAPI; i < pad_pkg::N_USB; i++) begin
				slot[i] = usb_joy[i - 1];
			end
		end
	end

	// ==================================================
	// Output registers
	// ==================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			for (int i = 0; i < pad_pkg::N_USB; i++) begin
				pce_joy[i] <= 12'hFFF;  // Nothing pressed
			end
			osd_button <= 1'b0;
		end else begin
			for (int i = 0; i < pad_pkg::N_USB; i++) begin
				pce_joy[i] <= to_console(slot[i]);
			end
			osd_button <= osd_a | osd_b;
		end
	end

	for (genvar g = 0; g < pad_pkg::N_USB; g++) begin : g_rst_chk
		a_idle_after_reset: assert property (
			@(posedge clk_sys) $past(reset) |-> (pce_joy[g] == 12'hFFF) && !osd_button
		);
	end

endmodule

`default_nettype wire

// File: rtl/pad_input_top.sv
`timescale 1ns/1ps
`default_nettype none

module pad_input_top (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic                 llapi_select,  // Serial mode chosen in the menu
	input  pad_pkg::llapi_port_t llapi_a,
	input  pad_pkg::llapi_port_t llapi_b,
	input  pad_pkg::pad_word_t   usb_joy [pad_pkg::N_USB],
	output logic [11:0]          pce_joy [pad_pkg::N_USB],
	output logic                 osd_button
);

	pad_pkg::pad_word_t ll_pad_a;
	pad_pkg::pad_word_t ll_pad_b;
	logic               use_a;
	logic               use_b;
	logic               osd_a;
	logic               osd_b;

	// ==================================================
	// Per-port decode
	// ==================================================

	pad_remap remap_a (
		.port (llapi_a),
		.pad  (ll_pad_a)
	);

	pad_remap remap_b (
		.port (llapi_b),
		.pad  (ll_pad_b)
	);

	pad_presence presence_a (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.llapi_select (llapi_select),
		.port         (llapi_a),
		.in_use       (use_a),
		.osd_combo    (osd_a)
	);

	pad_presence presence_b (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.llapi_select (llapi_select),
		.port         (llapi_b),
		.in_use       (use_b),
		.osd_combo    (osd_b)
	);

	// Player slots and console format
	player_slot_mux slot_mux (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.use_a      (use_a),
		.use_b      (use_b),
		.ll_pad_a   (ll_pad_a),
		.ll_pad_b   (ll_pad_b),
		.usb_joy    (usb_joy),
		.osd_a      (osd_a),
		.osd_b      (osd_b),
		.pce_joy    (pce_joy),
		.osd_button (osd_button)
	);

endmodule

`default_nettype wire

// File: include/pad_ref_model.svh
`ifndef PAD_REF_MODEL_SVH
`define PAD_REF_MODEL_SVH

// ==================================================
// Reference model of the pad input path
// ==================================================

// Face buttons listed from b6 down to b1, as LLAPI bit numbers
function automatic pad_pkg::pad_word_t ref_remap(pad_pkg::llapi_port_t p);
	int          idx [8];
	logic [7:0]  face;
	logic [11:0] w;
	case (p.ctype)
		pad_pkg::TYPE_GENESIS_A, pad_pkg::TYPE_GENESIS_B: idx = '{6, 3, 2, 0, 5, 4, 1, 7};
		pad_pkg::TYPE_TG16_A, pad_pkg::TYPE_TG16_B:       idx = '{3, 2, 8, 9, 5, 4, 0, 1};
		pad_pkg::TYPE_SATURN_A, pad_pkg::TYPE_SATURN_B:   idx = '{6, 3, 2, 0, 5, 9, 1, 7};
		default:                                          idx = '{7, 3, 6, 2, 5, 4, 0, 1};
	endcase
	for (int k = 0; k < 8; k++) begin
		face[7 - k] = p.buttons[idx[k]];
	end
	w = {face, p.buttons[27:24]};
	return w;
endfunction

// Pad seen in player slot s
function automatic pad_pkg::pad_word_t ref_slot(int s, logic use_a, logic use_b,
	pad_pkg::pad_word_t ll_a, pad_pkg::pad_word_t ll_b,
	pad_pkg::pad_word_t usb [pad_pkg::N_USB]);
	int u;
	if (s == 0 && use_a) return ll_a;
	if (s == 1 && use_b) return ll_b;
	u = s;
	if (use_a && s > 0) u = u - 1;  // Slots taken ahead of this one
	if (use_b && s > 1) u = u - 1;
	return usb[u];
endfunction

// Active-low word on the console joypad port
function automatic logic [11:0] ref_console(pad_pkg::pad_word_t p);
	logic [11:0] w;
	w = p;
	return ~{w[11:4], w[1], w[2], w[0], w[3]};
endfunction

`endif

// File: dv/pad_input_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pad_input_tb;

	localparam int TIMEOUT_NS = 200_000;  // Tests take about 2 us

	logic                 clk_sys;
	logic                 reset;
	logic                 llapi_select;
	pad_pkg::llapi_port_t llapi_a;
	pad_pkg::llapi_port_t llapi_b;
	pad_pkg::pad_word_t   usb_joy [pad_pkg::N_USB];
	logic [11:0]          pce_joy [pad_pkg::N_USB];
	logic                 osd_button;
	logic [31:0]          rng_state = 32'h83115077;
	int                   error_count = 0;
	int                   check_count = 0;

	`include "pad_ref_model.svh"

	pad_input_top pad_input_top_inst (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.llapi_select (llapi_select),
		.llapi_a      (llapi_a),
		.llapi_b      (llapi_b),
		.usb_joy      (usb_joy),
		.pce_joy      (pce_joy),
		.osd_button   (osd_button)
	);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	function automatic logic [31:0] next_rand();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	task automatic check(string name, logic [11:0] expected, logic [11:0] actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("Error %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic wait_sample();
		@(posedge clk_sys);
		#1;  // Registered outputs have settled
	endtask

	// ==================================================
	// Expected outputs for the inputs now applied
	// ==================================================

	task automatic check_outputs(string name, logic use_a, logic use_b);
		pad_pkg::pad_word_t pad_a;
		pad_pkg::pad_word_t pad_b;
		logic               osd;
		pad_a = ref_remap(llapi_a);
		pad_b = ref_remap(llapi_b);
		for (int s = 0; s < pad_pkg::N_USB; s++) begin
			check(name, ref_console(ref_slot(s, use_a, use_b, pad_a, pad_b, usb_joy)),
				pce_joy[s]);
		end
		osd = (llapi_a.buttons[26] & llapi_a.buttons[5] & llapi_a.buttons[0])
			| (llapi_b.buttons[26] & llapi_b.buttons[5] & llapi_b.buttons[0]);
		check(name, {11'd0, osd}, {11'd0, osd_button});
	endtask

	task automatic random_usb();
		logic [31:0] r;
		for (int i = 0; i < pad_pkg::N_USB; i++) begin
			r = next_rand();
			usb_joy[i] = r[11:0];
		end
	endtask

	task automatic hold_reset();
		repeat (4) begin
			wait_sample();
			for (int s = 0; s < pad_pkg::N_USB; s++) begin
				check("reset", 12'hFFF, pce_joy[s]);
			end
			check("reset", 12'd0, {11'd0, osd_button});
		end
		@(negedge clk_sys);
		reset = 1'b0;
	endtask

	task automatic reset_dut();
		@(negedge clk_sys);
		reset = 1'b1;
		hold_reset();
	endtask

	task automatic set_ports(logic [7:0] type_a, logic [7:0] type_b, logic en_a, logic en_b);
		llapi_a.buttons = next_rand();
		llapi_a.ctype   = type_a;
		llapi_a.link_en = en_a;
		llapi_b.buttons = next_rand();
		llapi_b.ctype   = type_b;
		llapi_b.link_en = en_b;
		random_usb();
	endtask

	// ==================================================
	// Directed tests
	// ==================================================

	task automatic test_passthrough_and_remap();
		logic [7:0] fams [7];
		fams = '{pad_pkg::TYPE_GENESIS_A, pad_pkg::TYPE_GENESIS_B, pad_pkg::TYPE_TG16_A,
			pad_pkg::TYPE_TG16_B, pad_pkg::TYPE_SATURN_A, pad_pkg::TYPE_SATURN_B, 8'd99};
		repeat (10) begin
			@(negedge clk_sys);
			llapi_select = 1'b0;  // Serial pads ignored
			set_ports(pad_pkg::TYPE_GENESIS_A, pad_pkg::TYPE_TG16_A, 1'b1, 1'b1);
			wait_sample();
			check_outputs("usb_passthrough", 1'b0, 1'b0);
		end
		for (int f = 0; f < 7; f++) begin
			repeat (6) begin
				@(negedge clk_sys);
				llapi_select = 1'b1;
				set_ports(fams[f], fams[(f + 1) % 7], 1'b1, 1'b1);  // B one family ahead
				wait_sample();
				check_outputs("family_remap", 1'b1, 1'b1);
			end
		end
		for (int side = 0; side < 2; side++) begin
			repeat (8) begin
				@(negedge clk_sys);
				set_ports(pad_pkg::TYPE_TG16_A, pad_pkg::TYPE_SATURN_B, side == 0, side == 1);
				wait_sample();
				check_outputs("one_port", side == 0, side == 1);
			end
		end
	endtask

	task automatic test_type_zero();
		@(negedge clk_sys);
		llapi_a = '{buttons: 32'd0, ctype: 8'd0, link_en: 1'b1};
		llapi_b = '{buttons: 32'd0, ctype: 8'd0, link_en: 1'b1};
		reset_dut();
		repeat (2) begin
			wait_sample();
			check_outputs("type_zero", 1'b0, 1'b0);
		end
		@(negedge clk_sys);
		llapi_a.buttons = 32'h0000_0010;
		wait_sample();
		check_outputs("type_zero", 1'b0, 1'b0);  // Flag only now set
		@(negedge clk_sys);
		llapi_a.buttons = 32'd0;
		repeat (4) begin
			wait_sample();
			check_outputs("type_zero", 1'b1, 1'b0);
		end
		reset_dut();
		wait_sample();
		check_outputs("type_zero", 1'b0, 1'b0);
	endtask

	task automatic osd_case(logic [31:0] word_a, logic [31:0] word_b, logic expected);
		@(negedge clk_sys);
		llapi_a.buttons = word_a;
		llapi_b.buttons = word_b;
		wait_sample();
		check("osd", {11'd0, expected}, {11'd0, osd_button});
	endtask

	task automatic test_osd();
		logic [31:0] combo;
		combo = (32'd1 << 26) | (32'd1 << 5) | 32'd1;  // Down, run, B
		@(negedge clk_sys);
		llapi_select = 1'b0;
		osd_case(combo, 32'd0, 1'b1);
		osd_case(combo & ~32'h20, 32'd0, 1'b0);
		osd_case(32'd0, combo | 32'h0F00_0F00, 1'b1);
		osd_case(combo & ~32'd1, combo & ~(32'd1 << 26), 1'b0);
		osd_case(combo, combo, 1'b1);
		@(negedge clk_sys);
		llapi_select = 1'b1;
		osd_case(32'd0, combo, 1'b1);
	endtask

	initial begin
		reset = 1'b1;
		llapi_select = 1'b0;
		llapi_a = '0;
		llapi_b = '0;
		llapi_a.buttons = (32'd1 << 26) | (32'd1 << 5) | 32'd1;  // OSD combination held in reset
		random_usb();  // Live USB pads that reset must mask
		hold_reset();
		llapi_a = '0;
		for (int i = 0; i < pad_pkg::N_USB; i++) begin
			usb_joy[i] = '0;
		end
		wait_sample();
		check_outputs("reset", 1'b0, 1'b0);  // Idle inputs just after reset
		test_passthrough_and_remap();
		test_type_zero();
		test_osd();
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
+incdir+include
rtl/pad_pkg.sv
rtl/pad_remap.sv
rtl/pad_presence.sv
rtl/player_slot_mux.sv
rtl/pad_input_top.sv
dv/pad_input_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile with Verilator, run, then look for the fail message in the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module pad_input_tb -f build.f
./obj_dir/Vpad_input_tb > sim.log
cat sim.log
if grep -q "TESTBENCH FAILED" sim.log; then
	exit 1
fi
grep -q "TESTBENCH PASSED" sim.log
